// ==== hdl/decode_defines.svh ====
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// register and operand width.
`define DATA_WIDTH 32

// architectural registers, r0 included.
`define REG_COUNT 32

// target of jal, bltzal and bgezal.
`define LINK_REG 31

`endif

// ==== hdl/mipsDecodePkg.sv ====
`include "decode_defines.svh"

package mipsDecodePkg;

    typedef logic [31:0]                   instrT;
    typedef logic [$clog2(`REG_COUNT)-1:0] regIdT;
    typedef logic [`DATA_WIDTH-1:0]        dataT;
    typedef logic [15:0]                   imm16T;
    typedef logic [25:0]                   imm26T; // jump target, word index.
    typedef logic [4:0]                    shamtT;

    // coarse class of the decoded instruction.
    typedef enum logic [3:0] {
        OP_NOP     = 4'd0,
        OP_ALU     = 4'd1,
        OP_SHIFT   = 4'd2,
        OP_LOAD    = 4'd3,
        OP_STORE   = 4'd4,
        OP_BRANCH  = 4'd5,
        OP_JUMP    = 4'd6,
        OP_MULDIV  = 4'd7,
        OP_COP0    = 4'd8,
        OP_TRAP    = 4'd9,  // syscall and break.
        OP_TLB     = 4'd10,
        OP_CACHE   = 4'd11,
        OP_INVALID = 4'd15
    } opClassT;

endpackage

// ==== hdl/decodeIf.sv ====
`timescale 1ns/1ps

interface decodeIf;

    logic                   valid;
    mipsDecodePkg::regIdT   rs;
    mipsDecodePkg::regIdT   rt;
    mipsDecodePkg::regIdT   rd;
    mipsDecodePkg::shamtT   shamt;
    mipsDecodePkg::imm16T   imm16;
    mipsDecodePkg::imm26T   imm26;
    logic                   regWriteEnable; // already qualified by valid.
    mipsDecodePkg::regIdT   writeRegId;
    mipsDecodePkg::opClassT opClass;

    modport src (
        output valid, rs, rt, rd, shamt, imm16, imm26,
        output regWriteEnable, writeRegId, opClass
    );

    modport dst (
        input valid, rs, rt, rd, shamt, imm16, imm26,
        input regWriteEnable, writeRegId, opClass
    );

endinterface

// ==== hdl/decodeUnit.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module decodeUnit (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 instrValid,
    input  mipsDecodePkg::instrT instr,
    decodeIf.src                 dec
);

    mipsDecodePkg::instrT   instrQ;
    logic                   validQ;
    logic [5:0]             opCode;
    logic [5:0]             funct;
    logic                   isNop;
    logic                   special;
    logic                   regImm;
    logic                   aluImm;
    logic                   aluReg;
    logic                   shiftOp;
    logic                   loadOp;
    logic                   storeOp;
    logic                   branchOp;
    logic                   jumpOp;
    logic                   mulDivOp;
    logic                   cop0Op;
    logic                   trapOp;
    logic                   tlbOp;
    logic                   cacheOp;
    logic                   isJal;
    logic                   isJalr;
    logic                   isMfhi;
    logic                   isMflo;
    logic                   isMul;
    logic                   isMfc0;
    logic                   isMtc0;
    logic                   isEret;
    logic                   isBltzal;
    logic                   isBgezal;
    logic                   writesRt;
    logic                   writesRd;
    logic                   writesLink;
    mipsDecodePkg::opClassT opClass;
    mipsDecodePkg::regIdT   writeRegId;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
            instrQ <= '0;
        end else begin
            validQ <= instrValid;
            if (instrValid) begin
                instrQ <= instr; // held across idle cycles.
            end
        end
    end

    assign opCode = instrQ[31:26];
    assign funct  = instrQ[5:0];

    assign dec.valid = validQ;
    assign dec.rs    = instrQ[25:21];
    assign dec.rt    = instrQ[20:16];
    assign dec.rd    = instrQ[15:11];
    assign dec.shamt = instrQ[10:6];
    assign dec.imm16 = instrQ[15:0];
    assign dec.imm26 = instrQ[25:0];

    assign isNop   = (instrQ == 32'h0);
    assign special = (opCode == 6'h00);
    assign regImm  = (opCode == 6'h01);

    // single instructions that steer the write target.
    assign isJal    = (opCode == 6'h03);
    assign isJalr   = special && (funct == 6'h09);
    assign isMfhi   = special && (funct == 6'h10);
    assign isMflo   = special && (funct == 6'h12);
    assign isMul    = (opCode == 6'h1c) && (instrQ[10:0] == 11'h002);
    assign isMfc0   = (opCode == 6'h10) && (instrQ[25:21] == 5'h00);
    assign isMtc0   = (opCode == 6'h10) && (instrQ[25:21] == 5'h04);
    assign isEret   = (instrQ == 32'h4200_0018);
    assign isBltzal = regImm && (instrQ[20:16] == 5'h10);
    assign isBgezal = regImm && (instrQ[20:16] == 5'h11);

    // addi addiu slti sltiu andi ori xori lui.
    assign aluImm   = (opCode inside {[6'h08:6'h0f]});
    assign aluReg   = special && (funct inside {[6'h20:6'h27], 6'h2a, 6'h2b});
    assign shiftOp  = special && (funct inside {6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07});
    assign loadOp   = (opCode inside {6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26});
    assign storeOp  = (opCode inside {6'h28, 6'h29, 6'h2a, 6'h2b, 6'h2e});
    assign branchOp = (opCode inside {[6'h04:6'h07]}) ||
                      (regImm && (instrQ[20:16] inside {5'h00, 5'h01, 5'h10, 5'h11}));
    assign jumpOp   = (opCode == 6'h02) || isJal || isJalr || (special && (funct == 6'h08));
    assign mulDivOp = (special && (funct inside {[6'h10:6'h13], [6'h18:6'h1b]})) || isMul;
    assign cop0Op   = isMfc0 || isMtc0 || isEret;
    assign trapOp   = special && (funct inside {6'h0c, 6'h0d});
    assign tlbOp    = (instrQ inside {32'h4200_0001, 32'h4200_0002,
                                      32'h4200_0006, 32'h4200_0008});
    assign cacheOp  = (opCode == 6'h2f);

    assign writesRt   = aluImm || loadOp || isMfc0; // lwl and lwr sit in loadOp.
    assign writesRd   = aluReg || shiftOp || isMfhi || isMflo || isMul || isJalr;
    assign writesLink = isJal || isBltzal || isBgezal;

    always_comb begin
        if (isNop) begin
            opClass = mipsDecodePkg::OP_NOP; // sll r0 wins over shift.
        end else if (aluImm || aluReg) begin
            opClass = mipsDecodePkg::OP_ALU;
        end else if (shiftOp) begin
            opClass = mipsDecodePkg::OP_SHIFT;
        end else if (loadOp) begin
            opClass = mipsDecodePkg::OP_LOAD;
        end else if (storeOp) begin
            opClass = mipsDecodePkg::OP_STORE;
        end else if (branchOp) begin
            opClass = mipsDecodePkg::OP_BRANCH;
        end else if (jumpOp) begin
            opClass = mipsDecodePkg::OP_JUMP;
        end else if (mulDivOp) begin
            opClass = mipsDecodePkg::OP_MULDIV;
        end else if (cop0Op) begin
            opClass = mipsDecodePkg::OP_COP0;
        end else if (trapOp) begin
            opClass = mipsDecodePkg::OP_TRAP;
        end else if (tlbOp) begin
            opClass = mipsDecodePkg::OP_TLB;
        end else if (cacheOp) begin
            opClass = mipsDecodePkg::OP_CACHE;
        end else begin
            opClass = mipsDecodePkg::OP_INVALID;
        end
    end

    always_comb begin
        if (writesRt) begin
            writeRegId = dec.rt;
        end else if (writesLink) begin
            writeRegId = mipsDecodePkg::regIdT'(`LINK_REG);
        end else begin
            writeRegId = dec.rd;
        end
    end

    assign dec.opClass        = opClass;
    assign dec.writeRegId     = writeRegId;
    assign dec.regWriteEnable = validQ && !isNop && (writesRt || writesRd || writesLink);

    // write decode and class decode are built separately, keep them consistent.
    wrEnHasClass: assert property (@(posedge clk) disable iff (!arstN)
        dec.regWriteEnable |->
            !(dec.opClass inside {mipsDecodePkg::OP_NOP, mipsDecodePkg::OP_INVALID}));

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module regFile (
    input  logic                 clk,
    input  logic                 arstN,
    input  mipsDecodePkg::regIdT raddrA,
    input  mipsDecodePkg::regIdT raddrB,
    output mipsDecodePkg::dataT  rdataA,
    output mipsDecodePkg::dataT  rdataB,
    input  logic                 wEnable,
    input  mipsDecodePkg::regIdT wAddr,
    input  mipsDecodePkg::dataT  wData
);

    mipsDecodePkg::dataT regs [`REG_COUNT];
    logic                wLive;

    assign wLive = wEnable && (wAddr != '0); // writes to r0 are dropped.

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wLive) begin
            regs[wAddr] <= wData;
        end
    end

    // same-cycle write is bypassed to the read.
    always_comb begin
        if (wLive && (wAddr == raddrA)) begin
            rdataA = wData;
        end else begin
            rdataA = regs[raddrA];
        end
    end

    always_comb begin
        if (wLive && (wAddr == raddrB)) begin
            rdataB = wData;
        end else begin
            rdataB = regs[raddrB];
        end
    end

    // r0 reads back as zero on both ports.
    r0StaysZero: assert property (@(posedge clk) disable iff (!arstN)
        ((raddrA != '0) || (rdataA == '0)) && ((raddrB != '0) || (rdataB == '0)));

endmodule

// ==== hdl/operandStage.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module operandStage (
    input  logic                   clk,
    input  logic                   arstN,
    decodeIf.dst                   dec,
    output mipsDecodePkg::regIdT   raddrA,
    output mipsDecodePkg::regIdT   raddrB,
    input  mipsDecodePkg::dataT    rdataA,
    input  mipsDecodePkg::dataT    rdataB,
    output logic                   outValid,
    output mipsDecodePkg::opClassT outOpClass,
    output mipsDecodePkg::regIdT   outRs,
    output mipsDecodePkg::regIdT   outRt,
    output mipsDecodePkg::shamtT   outShamt,
    output mipsDecodePkg::imm16T   outImm16,
    output mipsDecodePkg::imm26T   outImm26,
    output logic                   outRegWriteEnable,
    output mipsDecodePkg::regIdT   outWriteRegId,
    output mipsDecodePkg::dataT    outOperandA,
    output mipsDecodePkg::dataT    outOperandB
);

    assign raddrA = dec.rs;
    assign raddrB = dec.rt;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid          <= 1'b0;
            outRegWriteEnable <= 1'b0;
            outOpClass        <= mipsDecodePkg::OP_NOP;
            outRs             <= '0;
            outRt             <= '0;
            outShamt          <= '0;
            outImm16          <= '0;
            outImm26          <= '0;
            outWriteRegId     <= '0;
            outOperandA       <= {`DATA_WIDTH{1'b0}};
            outOperandB       <= {`DATA_WIDTH{1'b0}};
        end else begin
            // no stall, every cycle overwrites.
            outValid          <= dec.valid;
            outRegWriteEnable <= dec.regWriteEnable;
            outOpClass        <= dec.opClass;
            outRs             <= dec.rs;
            outRt             <= dec.rt;
            outShamt          <= dec.shamt;
            outImm16          <= dec.imm16;
            outImm26          <= dec.imm26;
            outWriteRegId     <= dec.writeRegId;
            outOperandA       <= rdataA;
            outOperandB       <= rdataB;
        end
    end

    // decode qualifies the write with valid one stage earlier.
    wrEnNeedsValid: assert property (@(posedge clk) disable iff (!arstN)
        outRegWriteEnable |-> outValid);

endmodule

// ==== hdl/decodeTop.sv ====
`timescale 1ns/1ps

module decodeTop (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   instrValid,
    input  mipsDecodePkg::instrT   instr,
    input  logic                   wbEnable,
    input  mipsDecodePkg::regIdT   wbRegId,
    input  mipsDecodePkg::dataT    wbData,
    output logic                   outValid,
    output mipsDecodePkg::opClassT outOpClass,
    output mipsDecodePkg::regIdT   outRs,
    output mipsDecodePkg::regIdT   outRt,
    output mipsDecodePkg::shamtT   outShamt,
    output mipsDecodePkg::imm16T   outImm16,
    output mipsDecodePkg::imm26T   outImm26,
    output logic                   outRegWriteEnable,
    output mipsDecodePkg::regIdT   outWriteRegId,
    output mipsDecodePkg::dataT    outOperandA,
    output mipsDecodePkg::dataT    outOperandB
);

    mipsDecodePkg::regIdT raddrA;
    mipsDecodePkg::regIdT raddrB;
    mipsDecodePkg::dataT  rdataA;
    mipsDecodePkg::dataT  rdataB;

    decodeIf decBus ();

    decodeUnit uDecode (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .dec        (decBus.src)
    );

    regFile uRegs (
        .clk     (clk),
        .arstN   (arstN),
        .raddrA  (raddrA),
        .raddrB  (raddrB),
        .rdataA  (rdataA),
        .rdataB  (rdataB),
        .wEnable (wbEnable),
        .wAddr   (wbRegId),
        .wData   (wbData)
    );

    operandStage uOperands (
        .clk               (clk),
        .arstN             (arstN),
        .dec               (decBus.dst),
        .raddrA            (raddrA),
        .raddrB            (raddrB),
        .rdataA            (rdataA),
        .rdataB            (rdataB),
        .outValid          (outValid),
        .outOpClass        (outOpClass),
        .outRs             (outRs),
        .outRt             (outRt),
        .outShamt          (outShamt),
        .outImm16          (outImm16),
        .outImm26          (outImm26),
        .outRegWriteEnable (outRegWriteEnable),
        .outWriteRegId     (outWriteRegId),
        .outOperandA       (outOperandA),
        .outOperandB       (outOperandB)
    );

endmodule

// ==== dv/decodeTb.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module decodeTb;

    localparam int CYCLE_LIMIT = 2000;

    typedef struct packed {
        int                     issued;
        mipsDecodePkg::instrT   word;
        mipsDecodePkg::opClassT opClass;
        logic                   wrEn;
        mipsDecodePkg::regIdT   wrId;
        mipsDecodePkg::regIdT   rs;
        mipsDecodePkg::regIdT   rt;
        mipsDecodePkg::shamtT   shamt;
        mipsDecodePkg::imm16T   imm16;
        mipsDecodePkg::imm26T   imm26;
        mipsDecodePkg::dataT    opA;
        mipsDecodePkg::dataT    opB;
    } expT;

    logic                   clk;
    logic                   arstN;
    logic                   instrValid;
    mipsDecodePkg::instrT   instr;
    logic                   wbEnable;
    mipsDecodePkg::regIdT   wbRegId;
    mipsDecodePkg::dataT    wbData;
    logic                   outValid;
    mipsDecodePkg::opClassT outOpClass;
    mipsDecodePkg::regIdT   outRs;
    mipsDecodePkg::regIdT   outRt;
    mipsDecodePkg::shamtT   outShamt;
    mipsDecodePkg::imm16T   outImm16;
    mipsDecodePkg::imm26T   outImm26;
    logic                   outRegWriteEnable;
    mipsDecodePkg::regIdT   outWriteRegId;
    mipsDecodePkg::dataT    outOperandA;
    mipsDecodePkg::dataT    outOperandB;

    mipsDecodePkg::dataT regModel [`REG_COUNT];
    expT                 expQ [$];
    int                  cycles = 0;
    int                  passCount = 0;
    int                  failCount = 0;
    integer              seed = 6823;

    decodeTop UUT (.*);

    always #10 clk = ~clk;

    // expected decode, taken from the instruction set rules.
    function automatic expT refDecode(input mipsDecodePkg::instrT w);
        expT        e;
        logic [5:0] op;
        logic [5:0] fn;
        logic       toRt;
        logic       toRd;
        logic       toLink;
        op = w[31:26];
        fn = w[5:0];
        toRt = 1'b0;
        toRd = 1'b0;
        toLink = 1'b0;
        e = '0;
        e.word = w;
        e.rs = w[25:21];
        e.rt = w[20:16];
        e.shamt = w[10:6];
        e.imm16 = w[15:0];
        e.imm26 = w[25:0];
        e.opClass = mipsDecodePkg::OP_INVALID;
        case (op)
            6'h00: begin
                case (fn)
                    6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07: begin
                        e.opClass = mipsDecodePkg::OP_SHIFT;
                        toRd = 1'b1;
                    end
                    6'h08: e.opClass = mipsDecodePkg::OP_JUMP; // jr.
                    6'h09: begin
                        e.opClass = mipsDecodePkg::OP_JUMP;
                        toRd = 1'b1;
                    end
                    6'h0c, 6'h0d: e.opClass = mipsDecodePkg::OP_TRAP;
                    6'h10, 6'h12: begin
                        e.opClass = mipsDecodePkg::OP_MULDIV; // mfhi, mflo.
                        toRd = 1'b1;
                    end
                    6'h11, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b: e.opClass = mipsDecodePkg::OP_MULDIV;
                    6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b: begin
                        e.opClass = mipsDecodePkg::OP_ALU;
                        toRd = 1'b1;
                    end
                    default: ;
                endcase
                if (w == '0) begin
                    e.opClass = mipsDecodePkg::OP_NOP;
                    toRd = 1'b0;
                end
            end
            6'h01: begin
                if (w[20:16] inside {5'h00, 5'h01, 5'h10, 5'h11}) begin
                    e.opClass = mipsDecodePkg::OP_BRANCH;
                    toLink = w[20]; // bltzal, bgezal.
                end
            end
            6'h02: e.opClass = mipsDecodePkg::OP_JUMP;
            6'h03: begin
                e.opClass = mipsDecodePkg::OP_JUMP;
                toLink = 1'b1;
            end
            6'h04, 6'h05, 6'h06, 6'h07: e.opClass = mipsDecodePkg::OP_BRANCH;
            6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
                e.opClass = mipsDecodePkg::OP_ALU;
                toRt = 1'b1;
            end
            6'h10: begin
                if (w[25:21] == 5'h00) begin
                    e.opClass = mipsDecodePkg::OP_COP0; // mfc0.
                    toRt = 1'b1;
                end else if (w[25:21] == 5'h04 || w == 32'h4200_0018) begin
                    e.opClass = mipsDecodePkg::OP_COP0;
                end else if (w inside {32'h4200_0001, 32'h4200_0002, 32'h4200_0006,
                                       32'h4200_0008}) begin
                    e.opClass = mipsDecodePkg::OP_TLB;
                end
            end
            6'h1c: begin
                if (w[10:0] == 11'h002) begin
                    e.opClass = mipsDecodePkg::OP_MULDIV;
                    toRd = 1'b1;
                end
            end
            6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26: begin
                e.opClass = mipsDecodePkg::OP_LOAD;
                toRt = 1'b1;
            end
            6'h28, 6'h29, 6'h2a, 6'h2b, 6'h2e: e.opClass = mipsDecodePkg::OP_STORE;
            6'h2f: e.opClass = mipsDecodePkg::OP_CACHE;
            default: ;
        endcase
        e.wrEn = toRt || toRd || toLink;
        e.wrId = toRt ? w[20:16] : (toLink ? mipsDecodePkg::regIdT'(`LINK_REG) : w[15:11]);
        return e;
    endfunction

    task automatic checkField(input string name, input logic [31:0] expV,
                              input logic [31:0] actV);
        if (expV !== actV) begin
            $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expV, actV);
            failCount++;
        end else begin
            passCount++;
        end
    endtask

    task automatic driveCycle(input logic v, input mipsDecodePkg::instrT w, input logic we,
                              input mipsDecodePkg::regIdT wa, input mipsDecodePkg::dataT wd);
        expT e;
        @(posedge clk);
        instrValid <= v;
        instr      <= w;
        wbEnable   <= we;
        wbRegId    <= wa;
        wbData     <= wd;
        if (we && wa != '0) begin
            regModel[wa] = wd; // r0 ignores writes.
        end
        if (v) begin
            e = refDecode(w);
            e.issued = cycles;
            expQ.push_back(e);
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) driveCycle(1'b0, '0, 1'b0, '0, '0);
    endtask

    task automatic finishTest(input int num, input string name);
        idleCycles(1);
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        $display("test %0d %s finished, %0d checks failed so far", num, name, failCount);
    endtask

    always @(negedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("cycle limit of %0d reached before the tests ended", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // compare process, outputs are stable at the falling edge.
    always @(negedge clk) begin
        expT e;
        if (arstN) begin
            foreach (expQ[i]) begin
                if (expQ[i].issued == cycles - 1) begin // read cycle, forwarding is in the model.
                    expQ[i].opA = regModel[expQ[i].rs];
                    expQ[i].opB = regModel[expQ[i].rt];
                end
            end
            if (outValid) begin
                if (expQ.size() == 0) begin
                    $display("outValid went high with no instruction outstanding");
                    failCount++;
                end else begin
                    e = expQ.pop_front();
                    checkField("latency", 32'd2, 32'(cycles - e.issued));
                    checkField("outOpClass", 32'(e.opClass), 32'(outOpClass));
                    checkField("outRegWriteEnable", 32'(e.wrEn), 32'(outRegWriteEnable));
                    if (e.wrEn) begin
                        checkField("outWriteRegId", 32'(e.wrId), 32'(outWriteRegId));
                    end
                    checkField("outRs", 32'(e.rs), 32'(outRs));
                    checkField("outRt", 32'(e.rt), 32'(outRt));
                    checkField("outShamt", 32'(e.shamt), 32'(outShamt));
                    checkField("outImm16", 32'(e.imm16), 32'(outImm16));
                    checkField("outImm26", 32'(e.imm26), 32'(outImm26));
                    checkField("outOperandA", e.opA, outOperandA);
                    checkField("outOperandB", e.opB, outOperandB);
                end
            end else if (expQ.size() != 0 && cycles - expQ[0].issued >= 2) begin
                e = expQ.pop_front();
                $display("no result came out for instruction %08h issued in cycle %0d",
                         e.word, e.issued);
                failCount++;
            end
        end
    end

    initial begin
        int                   i;
        logic [31:0]          r;
        logic [31:0]          w;
        mipsDecodePkg::regIdT k;
        clk = 1'b0;
        arstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        wbEnable = 1'b0;
        wbRegId = '0;
        wbData = '0;
        foreach (regModel[j]) begin
            regModel[j] = '0;
        end
        repeat (3) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkField("outValid", 32'd0, 32'(outValid));
        checkField("outRegWriteEnable", 32'd0, 32'(outRegWriteEnable));
        for (i = 0; i < 16; i++) begin
            k = mipsDecodePkg::regIdT'(2 * i);
            driveCycle(1'b1, {6'h00, k, k + 5'd1, 5'd1, 5'd0, 6'h20}, 1'b0, '0, '0);
        end
        finishTest(1, "reset");

        // addi add lw sw beq jal bltzal jalr mfc0 mul syscall nop.
        driveCycle(1'b1, 32'h2022_0005, 1'b0, '0, '0);
        driveCycle(1'b1, 32'h0022_1820, 1'b0, '0, '0);
        driveCycle(1'b1, 32'h8c45_0010, 1'b0, '0, '0);
        driveCycle(1'b1, 32'hac45_0010, 1'b0, '0, '0);
        driveCycle(1'b1, 32'h1022_0004, 1'b0, '0, '0);
        driveCycle(1'b1, 32'h0c00_0100, 1'b0, '0, '0);
        driveCycle(1'b1, 32'h0410_0003, 1'b0, '0, '0);
        driveCycle(1'b1, 32'h0020_f809, 1'b0, '0, '0);
        driveCycle(1'b1, 32'h4004_6000, 1'b0, '0, '0);
        driveCycle(1'b1, 32'h7062_2002, 1'b0, '0, '0);
        driveCycle(1'b1, 32'h0000_000c, 1'b0, '0, '0);
        driveCycle(1'b1, 32'h0000_0000, 1'b0, '0, '0);
        finishTest(2, "write targets");

        for (i = 0; i < 200; i++) begin
            w = $random(seed);
            if (w[1:0] == 2'b00) begin
                w[31:26] = 6'h00; // lean on the special opcode.
            end
            driveCycle(1'b1, w, 1'b0, '0, '0);
            if (($random(seed) & 7) == 0) begin
                idleCycles(1);
            end
        end
        finishTest(3, "fields");

        for (i = 0; i < 40; i++) begin
            r = $random(seed);
            driveCycle(1'b1, {6'h00, r[4:0], r[9:5], 5'd1, 5'd0, 6'h21}, r[10], r[15:11],
                       $random(seed));
        end
        driveCycle(1'b0, '0, 1'b1, '0, 32'hdead_beef);
        driveCycle(1'b1, 32'h0000_0821, 1'b0, '0, '0); // addu r1, r0, r0.
        finishTest(4, "operands");

        for (i = 0; i < 8; i++) begin
            r = $random(seed);
            k = (r[4:0] == 5'd0) ? 5'd7 : r[4:0];
            driveCycle(1'b1, {6'h00, k, k ^ 5'd1, 5'd2, 5'd0, 6'h21}, 1'b0, '0, '0);
            driveCycle(1'b0, '0, 1'b1, k, $random(seed)); // lands in the read cycle.
        end
        finishTest(5, "forwarding");

        if (expQ.size() != 0) begin
            $display("%0d expected results never came out", expQ.size());
            failCount++;
        end
        $display("checks passed: %0d, checks failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/mipsDecodePkg.sv
hdl/decodeIf.sv
hdl/decodeUnit.sv
hdl/regFile.sv
hdl/operandStage.sv
hdl/decodeTop.sv
dv/decodeTb.sv

// ==== run.sh ====
#!/bin/sh
# build the decode stage testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module decodeTb -o decodeSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/decodeSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1
